//--- source/mbist_config.svh
`ifndef MBIST_CONFIG_SVH
`define MBIST_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory geometry under test
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MBIST_DATA_W 16 // word width, also the lfsr width
`define MBIST_ADDR_W 6
`define MBIST_DEPTH  64 // 2**MBIST_ADDR_W

`endif

//--- source/mbist_pkg.sv
`include "mbist_config.svh"

package mbist_pkg;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // memory request, shared by host, engine and ram
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        typedef struct packed {
                logic                     we;    // 1 = write, 0 = read
                logic [`MBIST_ADDR_W-1:0] addr;
                logic [`MBIST_DATA_W-1:0] wdata; // ignored on reads
        } mem_req_t;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // engine control and status
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        typedef enum logic [1:0] {
                MODE_FILL       = 2'd0, // write pattern only
                MODE_CHECK      = 2'd1, // read back and compare only
                MODE_FILL_CHECK = 2'd2
        } bist_mode_e;

        typedef struct packed {
                logic [`MBIST_ADDR_W:0]   err_count;      // one extra bit, all words may fail
                logic [`MBIST_ADDR_W-1:0] first_err_addr; // lowest failing address
        } bist_result_t;

endpackage

//--- source/lfsr.sv
module lfsr #(
        parameter int NUM_BITS = 16
) (
        input  logic                i_Clk,
        input  logic                i_rst,
        input  logic                i_enable,
        input  logic                i_seed_dv,
        input  logic [NUM_BITS-1:0] i_seed_data,
        output logic [NUM_BITS-1:0] o_lfsr_data,
        output logic                o_lfsr_done
);

        logic [NUM_BITS:1] r_lfsr; // bit numbering follows the tap table
        logic              r_xnor;

        always_ff @(posedge i_Clk) begin
                if (i_rst) begin
                        r_lfsr <= '0; // zero is a legal xnor state
                end else if (i_enable) begin
                        if (i_seed_dv)
                                r_lfsr <= i_seed_data;
                        else
                                r_lfsr <= {r_lfsr[NUM_BITS-1:1], r_xnor};
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // maximal-length feedback taps, 3 to 32 bits
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always_comb begin
                case (NUM_BITS)
                        3:  r_xnor = r_lfsr[3] ^~ r_lfsr[2];
                        4:  r_xnor = r_lfsr[4] ^~ r_lfsr[3];
                        5:  r_xnor = r_lfsr[5] ^~ r_lfsr[3];
                        6:  r_xnor = r_lfsr[6] ^~ r_lfsr[5];
                        7:  r_xnor = r_lfsr[7] ^~ r_lfsr[6];
                        8:  r_xnor = r_lfsr[8] ^~ r_lfsr[6] ^~ r_lfsr[5] ^~ r_lfsr[4];
                        9:  r_xnor = r_lfsr[9] ^~ r_lfsr[5];
                        10: r_xnor = r_lfsr[10] ^~ r_lfsr[7];
                        11: r_xnor = r_lfsr[11] ^~ r_lfsr[9];
                        12: r_xnor = r_lfsr[12] ^~ r_lfsr[6] ^~ r_lfsr[4] ^~ r_lfsr[1];
                        13: r_xnor = r_lfsr[13] ^~ r_lfsr[4] ^~ r_lfsr[3] ^~ r_lfsr[1];
                        14: r_xnor = r_lfsr[14] ^~ r_lfsr[5] ^~ r_lfsr[3] ^~ r_lfsr[1];
                        15: r_xnor = r_lfsr[15] ^~ r_lfsr[14];
                        16: r_xnor = r_lfsr[16] ^~ r_lfsr[15] ^~ r_lfsr[13] ^~ r_lfsr[4];
                        17: r_xnor = r_lfsr[17] ^~ r_lfsr[14];
                        18: r_xnor = r_lfsr[18] ^~ r_lfsr[11];
                        19: r_xnor = r_lfsr[19] ^~ r_lfsr[6] ^~ r_lfsr[2] ^~ r_lfsr[1];
                        20: r_xnor = r_lfsr[20] ^~ r_lfsr[17];
                        21: r_xnor = r_lfsr[21] ^~ r_lfsr[19];
                        22: r_xnor = r_lfsr[22] ^~ r_lfsr[21];
                        23: r_xnor = r_lfsr[23] ^~ r_lfsr[18];
                        24: r_xnor = r_lfsr[24] ^~ r_lfsr[23] ^~ r_lfsr[22] ^~ r_lfsr[17];
                        25: r_xnor = r_lfsr[25] ^~ r_lfsr[22];
                        26: r_xnor = r_lfsr[26] ^~ r_lfsr[6] ^~ r_lfsr[2] ^~ r_lfsr[1];
                        27: r_xnor = r_lfsr[27] ^~ r_lfsr[5] ^~ r_lfsr[2] ^~ r_lfsr[1];
                        28: r_xnor = r_lfsr[28] ^~ r_lfsr[25];
                        29: r_xnor = r_lfsr[29] ^~ r_lfsr[27];
                        30: r_xnor = r_lfsr[30] ^~ r_lfsr[6] ^~ r_lfsr[4] ^~ r_lfsr[1];
                        31: r_xnor = r_lfsr[31] ^~ r_lfsr[28];
                        32: r_xnor = r_lfsr[32] ^~ r_lfsr[22] ^~ r_lfsr[2] ^~ r_lfsr[1];
                        default: r_xnor = 1'b0; // width outside the table
                endcase
        end

        assign o_lfsr_data = r_lfsr[NUM_BITS:1];
        assign o_lfsr_done = (r_lfsr[NUM_BITS:1] == i_seed_data);

endmodule

//--- source/bist_engine.sv
`include "mbist_config.svh"

module bist_engine (
        input  logic                     i_Clk,
        input  logic                     i_rst,
        input  logic                     i_start,
        input  mbist_pkg::bist_mode_e    i_mode,
        input  logic [`MBIST_DATA_W-1:0] i_seed,
        input  logic                     i_gnt,
        input  logic                     i_rvalid,
        input  logic [`MBIST_DATA_W-1:0] i_rdata,
        output logic                     o_req,
        output mbist_pkg::mem_req_t      o_cmd,
        output logic                     o_busy,
        output logic                     o_done,
        output mbist_pkg::bist_result_t  o_result
);

        localparam int ADDR_W = `MBIST_ADDR_W;
        localparam int DATA_W = `MBIST_DATA_W;
        localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`MBIST_DEPTH - 1);

        typedef enum logic [1:0] {S_IDLE, S_FILL, S_CHECK, S_FINISH} state_e;

        state_e                r_state;
        mbist_pkg::bist_mode_e r_mode;
        logic [DATA_W-1:0]     r_seed;
        logic [ADDR_W:0]       r_addr;      // issue address, msb marks all reads issued
        logic [ADDR_W-1:0]     r_cmp;       // compare count
        logic [ADDR_W:0]       r_err_count;
        logic [ADDR_W-1:0]     r_first_err;

        logic              start_ok;
        logic              fill_step;
        logic              fill_last;
        logic              chk_step;
        logic              chk_last;
        logic              reseed;
        logic              lfsr_en;
        logic              lfsr_load;
        logic [DATA_W-1:0] lfsr_seed;
        logic [DATA_W-1:0] lfsr_q;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // pattern generator
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign start_ok  = i_start && (r_state == S_IDLE || r_state == S_FINISH);
        assign fill_step = (r_state == S_FILL) && i_gnt;
        assign fill_last = fill_step && (r_addr[ADDR_W-1:0] == LAST_ADDR);
        assign chk_step  = (r_state == S_CHECK) && i_rvalid;
        assign chk_last  = chk_step && (r_cmp == LAST_ADDR);
        assign reseed    = fill_last && (r_mode == mbist_pkg::MODE_FILL_CHECK);
        assign lfsr_load = start_ok || reseed;
        assign lfsr_en   = lfsr_load || fill_step || chk_step;
        assign lfsr_seed = start_ok ? i_seed : r_seed;

        lfsr #(
                .NUM_BITS    (DATA_W)
        ) u_lfsr (
                .i_Clk       (i_Clk),
                .i_rst       (i_rst),
                .i_enable    (lfsr_en),
                .i_seed_dv   (lfsr_load),
                .i_seed_data (lfsr_seed),
                .o_lfsr_data (lfsr_q),
                .o_lfsr_done ()
        );

        always_ff @(posedge i_Clk) begin
                if (start_ok)
                        r_seed <= i_seed; // kept for the reseed before check
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // sequencer
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always_ff @(posedge i_Clk) begin
                if (i_rst) begin
                        r_state     <= S_IDLE;
                        r_mode      <= mbist_pkg::MODE_FILL;
                        r_addr      <= '0;
                        r_cmp       <= '0;
                        r_err_count <= '0;
                        r_first_err <= '0;
                end else begin
                        case (r_state)
                                S_IDLE, S_FINISH: begin
                                        r_state <= S_IDLE;
                                        if (start_ok) begin
                                                r_mode      <= i_mode;
                                                r_addr      <= '0;
                                                r_cmp       <= '0;
                                                r_err_count <= '0;
                                                r_first_err <= '0;
                                                if (i_mode == mbist_pkg::MODE_CHECK)
                                                        r_state <= S_CHECK;
                                                else
                                                        r_state <= S_FILL;
                                        end
                                end
                                S_FILL: begin
                                        if (fill_step)
                                                r_addr <= r_addr + 1'b1;
                                        if (reseed) begin
                                                r_state <= S_CHECK;
                                                r_addr  <= '0;
                                        end else if (fill_last) begin
                                                r_state <= S_FINISH;
                                        end
                                end
                                S_CHECK: begin
                                        if (o_req && i_gnt)
                                                r_addr <= r_addr + 1'b1;
                                        if (chk_step) begin
                                                r_cmp <= r_cmp + 1'b1;
                                                if (i_rdata != lfsr_q) begin
                                                        r_err_count <= r_err_count + 1'b1;
                                                        if (r_err_count == '0)
                                                                r_first_err <= r_cmp;
                                                end
                                                if (chk_last)
                                                        r_state <= S_FINISH;
                                        end
                                end
                                default: r_state <= S_IDLE;
                        endcase
                end
        end

        assign o_req = (r_state == S_FILL) || (r_state == S_CHECK && !r_addr[ADDR_W]);

        assign o_cmd.we    = (r_state == S_FILL);
        assign o_cmd.addr  = r_addr[ADDR_W-1:0];
        assign o_cmd.wdata = lfsr_q;

        assign o_busy = (r_state == S_FILL) || (r_state == S_CHECK);
        assign o_done = (r_state == S_FINISH);

        assign o_result.err_count      = r_err_count;
        assign o_result.first_err_addr = r_first_err;

endmodule

//--- source/mem_arbiter.sv
module mem_arbiter (
        input  logic                i_Clk,
        input  logic                i_rst,
        input  logic                i_host_req,
        input  mbist_pkg::mem_req_t i_host_cmd,
        input  logic                i_bist_req,
        input  mbist_pkg::mem_req_t i_bist_cmd,
        output logic                o_bist_gnt,
        output logic                o_mem_en,
        output mbist_pkg::mem_req_t o_mem_cmd,
        output logic                o_host_rvalid,
        output logic                o_bist_rvalid
);

        logic r_host_rd; // a host read is in the ram output stage
        logic r_bist_rd;

        assign o_bist_gnt = i_bist_req && !i_host_req; // host always wins
        assign o_mem_en   = i_host_req || i_bist_req;
        assign o_mem_cmd  = i_host_req ? i_host_cmd : i_bist_cmd;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // read ownership, one cycle behind the request
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always_ff @(posedge i_Clk) begin
                if (i_rst) begin
                        r_host_rd <= 1'b0;
                        r_bist_rd <= 1'b0;
                end else begin
                        r_host_rd <= i_host_req && !i_host_cmd.we;
                        r_bist_rd <= o_bist_gnt && !i_bist_cmd.we;
                end
        end

        assign o_host_rvalid = r_host_rd;
        assign o_bist_rvalid = r_bist_rd;

endmodule

//--- source/sram_1p.sv
`include "mbist_config.svh"

module sram_1p (
        input  logic                     i_Clk,
        input  logic                     i_en,
        input  mbist_pkg::mem_req_t      i_cmd,
        output logic [`MBIST_DATA_W-1:0] o_rdata
);

        logic [`MBIST_DATA_W-1:0] r_mem [`MBIST_DEPTH];

        always_ff @(posedge i_Clk) begin
                if (i_en) begin
                        if (i_cmd.we)
                                r_mem[i_cmd.addr] <= i_cmd.wdata;
                        else
                                o_rdata <= r_mem[i_cmd.addr]; // holds between reads
                end
        end

endmodule

//--- source/mbist_top.sv
`include "mbist_config.svh"

module mbist_top (
        input  logic                     i_Clk,
        input  logic                     i_rst,
        input  logic                     i_host_req,
        input  mbist_pkg::mem_req_t      i_host_cmd,
        input  logic                     i_start,
        input  mbist_pkg::bist_mode_e    i_mode,
        input  logic [`MBIST_DATA_W-1:0] i_seed,
        output logic                     o_host_rvalid,
        output logic [`MBIST_DATA_W-1:0] o_host_rdata,
        output logic                     o_busy,
        output logic                     o_done,
        output mbist_pkg::bist_result_t  o_result
);

        logic                     bist_req;
        mbist_pkg::mem_req_t      bist_cmd;
        logic                     bist_gnt;
        logic                     bist_rvalid;
        logic                     mem_en;
        mbist_pkg::mem_req_t      mem_cmd;
        logic [`MBIST_DATA_W-1:0] mem_rdata; // shared by host and engine

        bist_engine u_engine (
                .i_Clk    (i_Clk),
                .i_rst    (i_rst),
                .i_start  (i_start),
                .i_mode   (i_mode),
                .i_seed   (i_seed),
                .i_gnt    (bist_gnt),
                .i_rvalid (bist_rvalid),
                .i_rdata  (mem_rdata),
                .o_req    (bist_req),
                .o_cmd    (bist_cmd),
                .o_busy   (o_busy),
                .o_done   (o_done),
                .o_result (o_result)
        );

        mem_arbiter u_arbiter (
                .i_Clk         (i_Clk),
                .i_rst         (i_rst),
                .i_host_req    (i_host_req),
                .i_host_cmd    (i_host_cmd),
                .i_bist_req    (bist_req),
                .i_bist_cmd    (bist_cmd),
                .o_bist_gnt    (bist_gnt),
                .o_mem_en      (mem_en),
                .o_mem_cmd     (mem_cmd),
                .o_host_rvalid (o_host_rvalid),
                .o_bist_rvalid (bist_rvalid)
        );

        sram_1p u_sram (
                .i_Clk   (i_Clk),
                .i_en    (mem_en),
                .i_cmd   (mem_cmd),
                .o_rdata (mem_rdata)
        );

        assign o_host_rdata = mem_rdata;

endmodule

//--- bench/tb_mbist.sv
`include "mbist_config.svh"

module tb_mbist;

        timeunit 1ns;
        timeprecision 100ps;

        localparam int DATA_W      = `MBIST_DATA_W;
        localparam int ADDR_W      = `MBIST_ADDR_W;
        localparam int DEPTH       = `MBIST_DEPTH;
        localparam int CLK_PERIOD  = 100;
        localparam int RUN_CYC     = 2 * DEPTH + 1;               // fill plus check without stalls
        localparam int TOTAL_CYC   = 3 + 8 * RUN_CYC + 2 * DEPTH; // runs with room for stalls
        localparam int RUN_LIMIT   = 10 * RUN_CYC;
        localparam int WATCHDOG_NS = 20 * TOTAL_CYC * CLK_PERIOD;
        localparam mbist_pkg::mem_req_t IDLE_CMD = '0;

        logic                    i_Clk;
        logic                    i_rst;
        logic                    i_host_req;
        mbist_pkg::mem_req_t     i_host_cmd;
        logic                    i_start;
        mbist_pkg::bist_mode_e   i_mode;
        logic [DATA_W-1:0]       i_seed;
        logic                    o_host_rvalid;
        logic [DATA_W-1:0]       o_host_rdata;
        logic                    o_busy;
        logic                    o_done;
        mbist_pkg::bist_result_t o_result;

        mbist_top u_dut (.*);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // reference model state
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        logic [31:0]             lcg_state = 32'd68601;
        logic [DATA_W-1:0]       seq [DEPTH];    // expected pattern of the current run
        logic [DATA_W-1:0]       shadow [DEPTH]; // mirror of the ram
        mbist_pkg::bist_mode_e   mode_drv;
        logic [DATA_W-1:0]       seed_drv;
        mbist_pkg::bist_result_t exp_result;
        logic                    pend_rd;        // host read waiting for its rvalid
        logic [DATA_W-1:0]       pend_exp;
        logic                    busy_exp;
        logic                    done_exp;
        int                      grants;         // engine grants since start
        int                      fill_len;
        int                      need;           // grants the whole run takes
        int                      done_count;

        function logic [31:0] next_rand();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return lcg_state;
        endfunction

        function automatic logic [DATA_W-1:0] rand_seed();
                logic [DATA_W-1:0] s;
                s = '1;
                while (s == '1) // all ones locks up xnor feedback
                        s = DATA_W'(next_rand() >> 12);
                return s;
        endfunction

        // taps 16 15 13 4
        function automatic logic [DATA_W-1:0] lfsr_next(input logic [DATA_W-1:0] s);
                return {s[DATA_W-2:0], ~(s[15] ^ s[14] ^ s[12] ^ s[3])};
        endfunction

        function automatic mbist_pkg::bist_result_t expect_check();
                mbist_pkg::bist_result_t r;
                r = '0;
                for (int k = 0; k < DEPTH; k++) begin
                        if (shadow[k] != seq[k]) begin
                                if (r.err_count == '0)
                                        r.first_err_addr = ADDR_W'(k);
                                r.err_count = r.err_count + 1'b1;
                        end
                end
                return r;
        endfunction

        task automatic fail_run(input string why);
                $display("%s", why);
                $display("Simulation finished: FAIL");
                $fatal(1, "stopped at the first failure");
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp)
                        fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                                  input logic [DATA_W-1:0] exp);
                if (got !== exp)
                        fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_result(input mbist_pkg::bist_result_t got,
                                    input mbist_pkg::bist_result_t exp);
                if (got !== exp)
                        fail_run($sformatf("Error: o_result got %h expected %h", got, exp));
        endtask

        // one clock, checks at the falling edge then drives the next inputs
        task automatic step(input logic req, input mbist_pkg::mem_req_t cmd, input logic start);
                @(negedge i_Clk);
                check_flag("o_done", o_done, done_exp);
                if (done_exp) begin
                        done_count++;
                        busy_exp = 1'b0;
                        check_result(o_result, exp_result);
                end
                done_exp = 1'b0;
                check_flag("o_busy", o_busy, busy_exp);
                check_flag("o_host_rvalid", o_host_rvalid, pend_rd);
                if (pend_rd)
                        check_word("o_host_rdata", o_host_rdata, pend_exp);
                pend_rd = req && !cmd.we;
                if (pend_rd)
                        pend_exp = shadow[cmd.addr];
                if (req && cmd.we)
                        shadow[cmd.addr] = cmd.wdata;
                if (busy_exp && grants < need) begin
                        if (!req) begin // engine owns the coming edge
                                if (grants < fill_len)
                                        shadow[grants] = seq[grants];
                                grants++;
                                done_exp = (grants == need) && (fill_len == need);
                        end
                end else if (busy_exp) begin
                        done_exp = 1'b1; // last compare lands on the coming edge
                end
                if (start && !busy_exp) begin
                        seq[0] = seed_drv;
                        for (int k = 1; k < DEPTH; k++)
                                seq[k] = lfsr_next(seq[k-1]);
                        grants   = 0;
                        busy_exp = 1'b1;
                        if (mode_drv == mbist_pkg::MODE_CHECK) begin
                                fill_len   = 0;
                                need       = DEPTH;
                                exp_result = expect_check();
                        end else begin
                                fill_len   = DEPTH;
                                need       = (mode_drv == mbist_pkg::MODE_FILL) ? DEPTH
                                                                                : 2 * DEPTH;
                                exp_result = '0;
                        end
                end
                i_host_req = req;
                i_host_cmd = cmd;
                i_start    = start;
                i_mode     = mode_drv;
                i_seed     = seed_drv;
        endtask

        task automatic wait_done(input logic traffic);
                int                  first_done;
                int                  n;
                int                  safe;
                logic [31:0]         r;
                logic                req;
                mbist_pkg::mem_req_t cmd;
                first_done = done_count;
                n = 0;
                while (done_count == first_done) begin
                        req = 1'b0;
                        cmd = IDLE_CMD;
                        if (traffic) begin
                                r    = next_rand();
                                safe = grants - DEPTH - 1; // words already compared
                                req       = (r[31:29] < 3'd3);
                                cmd.we    = (safe > 0) && r[28];
                                cmd.wdata = DATA_W'(r >> 8);
                                if (cmd.we)
                                        cmd.addr = ADDR_W'(r[23:8] % safe);
                                else
                                        cmd.addr = ADDR_W'(r[23:16]);
                        end
                        step(req, cmd, 1'b0);
                        n++;
                        if (n > RUN_LIMIT)
                                fail_run("o_done did not arrive within the run limit");
                end
        endtask

        task automatic run_test(input mbist_pkg::bist_mode_e mode, input logic [DATA_W-1:0] seed,
                                input logic traffic);
                mode_drv = mode;
                seed_drv = seed;
                step(1'b0, IDLE_CMD, 1'b1);
                wait_done(traffic);
        endtask

        initial begin
                i_Clk = 1'b0;
                forever #(CLK_PERIOD / 2) i_Clk = ~i_Clk;
        end

        initial begin
                #(WATCHDOG_NS);
                fail_run("watchdog expired before the test sequence finished");
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // test sequence
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        initial begin
                logic [DATA_W-1:0]   seed;
                logic [31:0]         r;
                mbist_pkg::mem_req_t cmd;
                i_rst      = 1'b1;
                i_host_req = 1'b0;
                i_host_cmd = IDLE_CMD;
                i_start    = 1'b0;
                i_mode     = mbist_pkg::MODE_FILL;
                i_seed     = '0;
                mode_drv   = mbist_pkg::MODE_FILL;
                seed_drv   = '0;
                exp_result = '0;
                pend_rd    = 1'b0;
                pend_exp   = '0;
                busy_exp   = 1'b0;
                done_exp   = 1'b0;
                grants     = 0;
                fill_len   = 0;
                need       = 0;
                done_count = 0;
                for (int k = 0; k < DEPTH; k++)
                        shadow[k] = '0;
                repeat (3) @(negedge i_Clk);
                i_rst = 1'b0;

                step(1'b0, IDLE_CMD, 1'b0); // busy, done and rvalid checked low in here
                check_result(o_result, '0);

                run_test(mbist_pkg::MODE_FILL, rand_seed(), 1'b0);
                for (int k = 0; k < DEPTH; k++) begin // read back the whole pattern
                        cmd      = IDLE_CMD;
                        cmd.addr = ADDR_W'(k);
                        step(1'b1, cmd, 1'b0);
                end
                step(1'b0, IDLE_CMD, 1'b0);

                run_test(mbist_pkg::MODE_FILL_CHECK, rand_seed(), 1'b0);

                seed = rand_seed();
                run_test(mbist_pkg::MODE_FILL, seed, 1'b0);
                for (int k = 0; k < DEPTH; k++) begin
                        r = next_rand();
                        if (r[17:16] == 2'b00) begin // corrupt about a quarter of the words
                                cmd.we    = 1'b1;
                                cmd.addr  = ADDR_W'(k);
                                cmd.wdata = seq[k] ^ (DATA_W'(r >> 20) | DATA_W'(1));
                                step(1'b1, cmd, 1'b0);
                        end
                end
                run_test(mbist_pkg::MODE_CHECK, seed, 1'b0);

                run_test(mbist_pkg::MODE_FILL_CHECK, rand_seed(), 1'b1);
                step(1'b0, IDLE_CMD, 1'b0);

                // second start while busy must be dropped
                mode_drv = mbist_pkg::MODE_FILL_CHECK;
                seed_drv = rand_seed();
                step(1'b0, IDLE_CMD, 1'b1);
                step(1'b0, IDLE_CMD, 1'b0);
                mode_drv = mbist_pkg::MODE_CHECK;
                seed_drv = seed_drv ^ 16'h5a5a;
                step(1'b0, IDLE_CMD, 1'b1);
                wait_done(1'b0);
                repeat (4) step(1'b0, IDLE_CMD, 1'b0); // no further o_done expected

                $display("Simulation finished: PASS");
                $finish;
        end

endmodule

//--- vlog.f
+incdir+source
source/mbist_pkg.sv
source/lfsr.sv
source/bist_engine.sv
source/mem_arbiter.sv
source/sram_1p.sv
source/mbist_top.sv
bench/tb_mbist.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
        --top-module tb_mbist \
        -f vlog.f \
        -o tb_mbist

./obj_dir/tb_mbist
